//--- bench/serial_loader_assert.sv
// Protocol assertions on the loader bound into the top level
// Reaches the parser state through the parser instance inside the top

`timescale 1ns/1ps

module serial_loader_assert (
	input  logic                      clk,
	input  logic                      rst_s,
	input  logic                      load_en,
	input  logic                      prog_wen,
	input  logic                      tx_start,
	input  logic                      tx_busy,
	input  logic                      tx,
	input  loader_pkg::parser_state_t state
);

	int fail_cnt = 0;

	// Write strobe is a single pulse
	wen_single: assert property (@(posedge clk) disable iff (rst_s) prog_wen |=> !prog_wen)
		else begin
			$error("prog_wen high for more than one cycle");
			fail_cnt++;
		end

	// Start bit and busy follow a start request on the next cycle
	start_bit: assert property (@(posedge clk) disable iff (rst_s)
		tx_start |=> tx_busy && !tx)
		else begin
			$error("No start bit on tx after tx_start");
			fail_cnt++;
		end

	// Idle line
	tx_idle_high: assert property (@(posedge clk) disable iff (rst_s) !tx_busy |-> tx)
		else begin
			$error("tx low while transmitter idle");
			fail_cnt++;
		end

	// Disabled loader parks the FSM one cycle later
	parked: assert property (@(posedge clk) disable iff (rst_s)
		!load_en |=> state == loader_pkg::st_wait_sop)
		else begin
			$error("Parser not idle with load_en low");
			fail_cnt++;
		end

endmodule

bind serial_loader serial_loader_assert assert_inst (
	.clk      (clk),
	.rst_s    (rst_s),
	.load_en  (load_en),
	.prog_wen (prog_wen),
	.tx_start (tx_start),
	.tx_busy  (tx_busy),
	.tx       (tx),
	.state    (packet_parser_inst.state)
);

//--- bench/serial_loader_checker.sv
// Scoreboard for program writes and response bytes
// Expectations are pushed in order by the testbench before each packet
// tx is decoded by mid-bit sampling on falling clock edges

`timescale 1ns/1ps
`include "loader_settings.svh"

module serial_loader_checker (
	input  logic              clk,
	input  logic              rst_s,
	input  logic              tx,
	input  logic              prog_wen,
	input  loader_pkg::addr_t prog_addr,
	input  loader_pkg::word_t prog_wdata
);

	localparam int CPB = `LOADER_CLKS_PER_BIT;

	loader_pkg::addr_t exp_addr[$];    // Pending writes in order
	loader_pkg::word_t exp_data[$];
	uart_pkg::byte_t   exp_resp[$];    // Pending response bytes
	int err_cnt    = 0;
	int test_errs  = 0;    // Errors inside current test
	int test_cnt   = 0;
	int failed_cnt = 0;
	int resp_cnt   = 0;    // Frames decoded so far

	task automatic note_error(input string msg);
		$display("%s", msg);
		err_cnt++;
		test_errs++;
	endtask

	task automatic expect_write(input loader_pkg::addr_t addr, input loader_pkg::word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic expect_resp(input uart_pkg::byte_t b);
		exp_resp.push_back(b);
	endtask

	////////////////////
	// Write port
	////////////////////
	always @(negedge clk) begin
		if (!rst_s && prog_wen === 1'b1) begin
			if (exp_addr.size() == 0) begin
				note_error($sformatf("Unexpected write to address %h", prog_addr));
			end else begin
				if (prog_addr !== exp_addr[0])
					note_error($sformatf("Fail prog_addr expected %h got %h",
						exp_addr[0], prog_addr));
				if (prog_wdata !== exp_data[0])
					note_error($sformatf("Fail prog_wdata expected %h got %h",
						exp_data[0], prog_wdata));
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	////////////////////
	// Response decode
	////////////////////
	initial begin : tx_decode
		uart_pkg::byte_t bits;
		uart_pkg::byte_t exp_b;
		forever begin
			@(negedge clk);
			if (!rst_s && tx === 1'b0) begin    // Start bit seen
				repeat (CPB / 2) @(negedge clk);    // Middle of start bit
				if (tx !== 1'b0)
					note_error("Start bit on tx shorter than half a bit");
				for (int i = 0; i < 8; i++) begin
					repeat (CPB) @(negedge clk);
					bits[i] = tx;    // LSB first
				end
				repeat (CPB) @(negedge clk);
				if (tx !== 1'b1)
					note_error("Stop bit on tx is low");
				if (exp_resp.size() == 0) begin
					note_error($sformatf("Unexpected response byte %h on tx", bits));
				end else begin
					exp_b = exp_resp.pop_front();
					if (bits !== exp_b)
						note_error($sformatf("Fail tx expected %h got %h", exp_b, bits));
				end
				resp_cnt++;
			end
		end
	end

	// Anything still pending counts as missing
	task automatic end_test(input string name);
		while (exp_addr.size() > 0) begin
			note_error($sformatf("Missing write to address %h", exp_addr.pop_front()));
			void'(exp_data.pop_front());
		end
		while (exp_resp.size() > 0)
			note_error($sformatf("Missing response byte %h", exp_resp.pop_front()));
		test_cnt++;
		if (test_errs == 0) begin
			$display("Test %0d %s: passed", test_cnt, name);
		end else begin
			failed_cnt++;
			$display("Test %0d %s: failed with %0d errors", test_cnt, name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic report();
		$display("%0d tests run, %0d failed, %0d errors", test_cnt, failed_cnt, err_cnt);
	endtask

endmodule

//--- bench/serial_loader_tb.sv
// Testbench for the serial loader
// Inputs change on falling edges only, 8N1 frames at the design baud rate
// Random words from a fixed seed, noise bytes never equal the start byte

`timescale 1ns/1ps
`include "loader_settings.svh"

module serial_loader_tb;

	localparam int CPB       = `LOADER_CLKS_PER_BIT;
	localparam int RAND_SEED = 32'hba76_cf71;
	localparam int NOISE     = 4;
	// Frames per test, response included
	localparam int FRAMES    = (NOISE + 19) + 19 + 19 + 15 + 7 + 19 + 19;
	localparam int CYCLE_LIMIT = 2 * FRAMES * 10 * CPB + 1000;

	logic              clk = 1'b0;
	logic              rst_s;
	logic              load_en;
	logic              rx;
	logic              tx;
	logic              prog_wen;
	loader_pkg::addr_t prog_addr;
	loader_pkg::word_t prog_wdata;
	int                cycles = 0;

	always #10 clk = ~clk;    // 20 ns period

	serial_loader serial_loader_inst (
		.clk        (clk),
		.rst_s      (rst_s),
		.load_en    (load_en),
		.rx         (rx),
		.tx         (tx),
		.prog_wen   (prog_wen),
		.prog_addr  (prog_addr),
		.prog_wdata (prog_wdata)
	);

	serial_loader_checker checker_inst (
		.clk        (clk),
		.rst_s      (rst_s),
		.tx         (tx),
		.prog_wen   (prog_wen),
		.prog_addr  (prog_addr),
		.prog_wdata (prog_wdata)
	);

	// Run guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////
	// Reference model
	////////////////////
	function automatic loader_pkg::csum_t data_sum(input loader_pkg::word_t words[$]);
		loader_pkg::csum_t sum;
		sum = '0;
		foreach (words[i])
			sum = sum + words[i][7:0] + words[i][15:8] + words[i][23:16] + words[i][31:24];
		return sum;
	endfunction

	// Expected response, and whether the words land in memory
	function automatic uart_pkg::byte_t expect_packet(input uart_pkg::byte_t cmd,
			input loader_pkg::word_t words[$], input bit csum_bad,
			input uart_pkg::byte_t eop, output bit writes);
		writes = (cmd == `LOADER_CMD_WR);
		if (!csum_bad && eop == `LOADER_EOP)
			return `LOADER_ACK;
		return data_sum(words);    // Error code is the true sum
	endfunction

	////////////////////
	// Stimulus
	////////////////////
	task automatic send_byte(input uart_pkg::byte_t b);
		rx = 1'b0;    // Start bit
		repeat (CPB) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (CPB) @(negedge clk);
		end
		rx = 1'b1;    // Stop bit
		repeat (CPB) @(negedge clk);
	endtask

	function automatic uart_pkg::byte_t noise_byte();
		uart_pkg::byte_t b;
		b = $urandom;
		if (b == `LOADER_SOP)
			b = b ^ 8'h01;
		return b;
	endfunction

	task automatic run_packet(input string name, input uart_pkg::byte_t cmd,
			input loader_pkg::word_t words[$], input bit csum_bad,
			input uart_pkg::byte_t eop, input bit expect_out);
		bit                writes;
		uart_pkg::byte_t   resp;
		uart_pkg::byte_t   csum_byte;
		loader_pkg::len_t  len;
		int                base;
		int                waited;
		resp      = expect_packet(cmd, words, csum_bad, eop, writes);
		csum_byte = data_sum(words) ^ (csum_bad ? 8'h5A : 8'h00);    // Corrupt on request
		len       = loader_pkg::len_t'(words.size());
		if (expect_out) begin
			if (writes)
				foreach (words[i])
					checker_inst.expect_write(loader_pkg::addr_t'(i), words[i]);
			checker_inst.expect_resp(resp);
		end
		base = checker_inst.resp_cnt;
		send_byte(`LOADER_SOP);
		send_byte(cmd);
		send_byte(len[7:0]);
		send_byte(len[15:8]);
		foreach (words[i])
			for (int b = 0; b < 4; b++)
				send_byte(words[i][8*b +: 8]);    // LSB first
		send_byte(csum_byte);
		send_byte(eop);
		waited = 0;
		if (expect_out) begin
			while (checker_inst.resp_cnt == base && waited < 30 * CPB) begin
				@(negedge clk);
				waited++;
			end
		end else begin
			repeat (30 * CPB) @(negedge clk);    // Quiet window
		end
		repeat (2 * CPB) @(negedge clk);    // Let tx_busy fall
		checker_inst.end_test(name);
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		loader_pkg::word_t words[$];
		rst_s   = 1'b1;
		load_en = 1'b0;
		rx      = 1'b1;
		void'($urandom(RAND_SEED));
		repeat (2) @(negedge clk);
		rst_s   = 1'b0;
		load_en = 1'b1;
		repeat (4) @(negedge clk);

		for (int i = 0; i < NOISE; i++)
			send_byte(noise_byte());
		repeat (3) words.push_back($urandom);
		run_packet("noise then write", `LOADER_CMD_WR, words, 1'b0, `LOADER_EOP, 1'b1);

		words.delete();
		repeat (3) words.push_back($urandom);
		run_packet("bad checksum", `LOADER_CMD_WR, words, 1'b1, `LOADER_EOP, 1'b1);

		words.delete();
		repeat (3) words.push_back($urandom);
		run_packet("bad end byte", `LOADER_CMD_WR, words, 1'b0, 8'h0A, 1'b1);

		words.delete();
		repeat (2) words.push_back($urandom);
		run_packet("other command", 8'h03, words, 1'b0, `LOADER_EOP, 1'b1);
		words.delete();
		run_packet("zero count", `LOADER_CMD_WR, words, 1'b0, `LOADER_EOP, 1'b1);

		// Loader switched off, then on again
		repeat (3) words.push_back($urandom);
		load_en = 1'b0;
		run_packet("loader disabled", `LOADER_CMD_WR, words, 1'b0, `LOADER_EOP, 1'b0);
		load_en = 1'b1;
		repeat (4) @(negedge clk);
		run_packet("loader enabled", `LOADER_CMD_WR, words, 1'b0, `LOADER_EOP, 1'b1);

		checker_inst.report();
		if (checker_inst.err_cnt == 0 && serial_loader_inst.assert_inst.fail_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- design/loader_pkg.sv
// Types for the packet and program memory layer
// Word address and count are 16 bits, so at most 65535 words per packet

package loader_pkg;

	////////////////////
	// Payload widths
	////////////////////
	typedef logic [31:0] word_t;    // Program word
	typedef logic [15:0] addr_t;    // Word address, not byte address
	typedef logic [15:0] len_t;     // Word count field
	typedef logic [7:0]  csum_t;    // Sum of data bytes mod 256

	////////////////////
	// Parser FSM
	////////////////////
	typedef enum logic [3:0] {
		st_wait_sop,    // Idle, hunting for start byte
		st_cmd,         // Command byte
		st_len_lo,      // Count, low byte
		st_len_hi,      // Count, high byte
		st_data,        // Data bytes, four per word
		st_csum,        // Checksum byte
		st_eop,         // End byte
		st_respond,     // Wait for idle transmitter
		st_wait_tx      // Response on the line
	} parser_state_t;

endpackage

//--- design/loader_settings.svh
// Serial loader constants shared by design and bench
// Baud rate is fixed by clocks per bit, no fractional divider
// Clocks per bit must fit the 8-bit baud counter (max 256)
// Even value preferred, mid-bit sampling uses half of it

`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

////////////////////
// Line timing
////////////////////
`define LOADER_CLKS_PER_BIT 16      // clk cycles per serial bit

////////////////////
// Packet framing
////////////////////
`define LOADER_SOP    8'h23         // Start of packet
`define LOADER_EOP    8'h0D         // End of packet
`define LOADER_CMD_WR 8'h07         // Write program memory

// Response on good packet
`define LOADER_ACK    8'h55

`endif

//--- design/packet_parser.sv
// Loader packet parser
// Packet: SOP, cmd, count lo, count hi, count x 4 data bytes, checksum, EOP
// Words arrive LSB first, addresses restart at 0 for every packet
// Words are written as they complete, a bad checksum cannot undo them
// Only the write command touches program memory
// No back-pressure on rx, bytes outside a packet or during a response are lost

`timescale 1ns/1ps
`include "loader_settings.svh"

module packet_parser (
	input  logic              clk,
	input  logic              rst_s,
	input  logic              load_en,
	input  logic              rx_valid,
	input  uart_pkg::byte_t   rx_byte,
	input  logic              tx_busy,
	output logic              tx_start,
	output uart_pkg::byte_t   tx_byte,
	output logic              prog_wen,
	output loader_pkg::addr_t prog_addr,
	output loader_pkg::word_t prog_wdata
);

	loader_pkg::parser_state_t state;
	uart_pkg::byte_t           cmd;         // Command of current packet
	loader_pkg::len_t          len;         // Words announced
	loader_pkg::addr_t         word_cnt;    // Words done, next address
	loader_pkg::csum_t         csum;        // Running sum of data bytes
	logic                      csum_ok;     // Checksum byte matched
	logic [1:0]                byte_idx;    // Byte inside current word
	loader_pkg::word_t         word_buf;    // Word being assembled
	logic                      is_write;
	logic                      word_done;   // Fourth byte of a word now
	logic                      last_word;
	loader_pkg::len_t          len_next;    // Full count as the high byte lands

	assign is_write  = (cmd == uart_pkg::byte_t'(`LOADER_CMD_WR));
	assign word_done = rx_valid && (state == loader_pkg::st_data) && (byte_idx == 2'd3);
	assign last_word = (word_cnt == loader_pkg::addr_t'(len - 16'd1));
	assign len_next  = {rx_byte, len[7:0]};

	// Response goes out once the transmitter is free
	assign tx_start = load_en && (state == loader_pkg::st_respond) && !tx_busy;

	////////////////////
	// Packet FSM
	////////////////////
	always_ff @(posedge clk or posedge rst_s) begin
		if (rst_s) begin
			state    <= loader_pkg::st_wait_sop;
			cmd      <= '0;
			len      <= '0;
			word_cnt <= '0;
			csum     <= '0;
			csum_ok  <= 1'b0;
			byte_idx <= '0;
			prog_wen <= 1'b0;
		end else begin
			prog_wen <= 1'b0;    // Write strobe is one cycle
			if (!load_en) begin
				state <= loader_pkg::st_wait_sop;    // Loader disabled, drop packet
			end else begin
				case (state)
				loader_pkg::st_wait_sop: begin
					if (rx_valid && rx_byte == uart_pkg::byte_t'(`LOADER_SOP)) begin
						state    <= loader_pkg::st_cmd;
						word_cnt <= '0;    // Addresses restart per packet
						csum     <= '0;
						byte_idx <= '0;
					end
				end
				loader_pkg::st_cmd: begin
					if (rx_valid) begin
						cmd   <= rx_byte;
						state <= loader_pkg::st_len_lo;
					end
				end
				loader_pkg::st_len_lo: begin
					if (rx_valid) begin
						len[7:0] <= rx_byte;
						state    <= loader_pkg::st_len_hi;
					end
				end
				loader_pkg::st_len_hi: begin
					if (rx_valid) begin
						len   <= len_next;
						// Empty packet skips the data phase
						state <= (len_next == '0) ? loader_pkg::st_csum : loader_pkg::st_data;
					end
				end
				loader_pkg::st_data: begin
					if (rx_valid) begin
						csum     <= csum + rx_byte;
						byte_idx <= byte_idx + 1'b1;    // Wraps after 4 bytes
					end
					if (word_done) begin
						prog_wen <= is_write;    // Other commands parse only
						word_cnt <= word_cnt + 1'b1;
						if (last_word)
							state <= loader_pkg::st_csum;
					end
				end
				loader_pkg::st_csum: begin
					if (rx_valid) begin
						csum_ok <= (rx_byte == csum);
						state   <= loader_pkg::st_eop;    // EOP awaited even on mismatch
					end
				end
				loader_pkg::st_eop: begin
					if (rx_valid)
						state <= loader_pkg::st_respond;
				end
				loader_pkg::st_respond: begin
					if (tx_start)
						state <= loader_pkg::st_wait_tx;
				end
				loader_pkg::st_wait_tx: begin
					if (!tx_busy)    // Busy is already up on entry
						state <= loader_pkg::st_wait_sop;
				end
				default: state <= loader_pkg::st_wait_sop;
				endcase
			end
		end
	end

	////////////////////
	// Payload
	////////////////////
	always_ff @(posedge clk) begin
		if (rx_valid && state == loader_pkg::st_data)
			word_buf <= {rx_byte, word_buf[31:8]};    // Little endian fill
		if (word_done) begin
			prog_wdata <= {rx_byte, word_buf[31:8]};
			prog_addr  <= word_cnt;
		end
		// ACK only if both checksum and end byte are good
		if (rx_valid && state == loader_pkg::st_eop) begin
			if (csum_ok && rx_byte == uart_pkg::byte_t'(`LOADER_EOP))
				tx_byte <= uart_pkg::byte_t'(`LOADER_ACK);
			else
				tx_byte <= uart_pkg::byte_t'(csum);    // Computed sum as error code
		end
	end

endmodule

//--- design/serial_loader.sv
// Serial program loader, top level
// Single clock, UART pace set by clocks per bit
// load_en low holds the parser idle, a response in flight still completes
// Program memory port is write only, one strobe per word

`timescale 1ns/1ps

module serial_loader (
	input  logic              clk,
	input  logic              rst_s,
	input  logic              load_en,    // Programming switch
	input  logic              rx,
	output logic              tx,
	output logic              prog_wen,
	output loader_pkg::addr_t prog_addr,
	output loader_pkg::word_t prog_wdata
);

	logic            rx_valid;
	uart_pkg::byte_t rx_byte;
	logic            tx_start;
	uart_pkg::byte_t tx_byte;
	logic            tx_busy;

	// Byte stream in
	uart_rx uart_rx_inst (
		.clk      (clk),
		.rst_s    (rst_s),
		.rx       (rx),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	// Packet decode and memory writes
	packet_parser packet_parser_inst (
		.clk        (clk),
		.rst_s      (rst_s),
		.load_en    (load_en),
		.rx_valid   (rx_valid),
		.rx_byte    (rx_byte),
		.tx_busy    (tx_busy),
		.tx_start   (tx_start),
		.tx_byte    (tx_byte),
		.prog_wen   (prog_wen),
		.prog_addr  (prog_addr),
		.prog_wdata (prog_wdata)
	);

	// Response byte out
	uart_tx uart_tx_inst (
		.clk      (clk),
		.rst_s    (rst_s),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

endmodule

//--- design/uart_pkg.sv
// Types for the serial line layer
// 8N1 framing only, no parity support

package uart_pkg;

	// One data byte on the line
	typedef logic [7:0] byte_t;

	// Clock count inside one bit time
	// Bounds clocks per bit to 256
	typedef logic [7:0] baud_cnt_t;

	// Bit slot inside a frame
	// 0 start, 1..8 data, 9 stop
	typedef logic [3:0] bit_idx_t;

endpackage

//--- design/uart_rx.sv
// 8N1 UART receiver with LSB first data
// rx is asynchronous and resynchronized here
// Start bit re-checked at mid-bit so glitches under half a bit are dropped
// Frames with a low stop bit are discarded silently
// rx_byte holds the last good byte until the next one

`timescale 1ns/1ps
`include "loader_settings.svh"

module uart_rx (
	input  logic            clk,
	input  logic            rst_s,
	input  logic            rx,
	output logic            rx_valid,
	output uart_pkg::byte_t rx_byte
);

	localparam uart_pkg::baud_cnt_t BIT_LAST  = uart_pkg::baud_cnt_t'(`LOADER_CLKS_PER_BIT - 1);
	localparam uart_pkg::baud_cnt_t HALF_LAST = uart_pkg::baud_cnt_t'(`LOADER_CLKS_PER_BIT / 2 - 1);

	logic                 rx_meta;    // First sync stage
	logic                 rx_sync;    // Second sync stage
	logic                 rx_prev;    // For falling edge detect
	logic                 busy;       // Frame in progress
	uart_pkg::baud_cnt_t  baud_cnt;
	uart_pkg::bit_idx_t   bit_idx;
	uart_pkg::byte_t      shreg;      // Data bits as they come in
	logic                 sample;     // Mid-bit strobe

	////////////////////
	// Input sync
	////////////////////
	always_ff @(posedge clk or posedge rst_s) begin
		if (rst_s) begin
			rx_meta <= 1'b1;    // Line idles high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// Half a bit for the start slot and whole bits after that
	assign sample = busy && (baud_cnt == ((bit_idx == '0) ? HALF_LAST : BIT_LAST));

	////////////////////
	// Frame control
	////////////////////
	always_ff @(posedge clk or posedge rst_s) begin
		if (rst_s) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;    // Single cycle pulse
			if (!busy) begin
				if (rx_prev && !rx_sync) begin    // Start bit edge
					busy     <= 1'b1;
					baud_cnt <= '0;
					bit_idx  <= '0;
				end
			end else if (sample) begin
				baud_cnt <= '0;
				bit_idx  <= bit_idx + 1'b1;
				if (bit_idx == '0 && rx_sync) begin
					busy <= 1'b0;    // False start as line is back high
				end else if (bit_idx == 4'd9) begin
					busy     <= 1'b0;    // Idle at mid stop bit
					rx_valid <= rx_sync; // Framing error gives no pulse
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// Data path
	always_ff @(posedge clk) begin
		if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			shreg <= {rx_sync, shreg[7:1]};    // LSB arrives first
		if (sample && bit_idx == 4'd9 && rx_sync)
			rx_byte <= shreg;
	end

endmodule

//--- design/uart_tx.sv
// 8N1 UART transmitter with LSB first data
// tx_start is only honored while tx_busy is low
// tx_busy drops at the end of the stop bit with the line high

`timescale 1ns/1ps
`include "loader_settings.svh"

module uart_tx (
	input  logic            clk,
	input  logic            rst_s,
	input  logic            tx_start,
	input  uart_pkg::byte_t tx_byte,
	output logic            tx,
	output logic            tx_busy
);

	localparam uart_pkg::baud_cnt_t BIT_LAST = uart_pkg::baud_cnt_t'(`LOADER_CLKS_PER_BIT - 1);

	uart_pkg::baud_cnt_t baud_cnt;
	uart_pkg::bit_idx_t  bit_idx;    // Slot now on the line
	uart_pkg::byte_t     shreg;      // Bits still to send
	logic                bit_end;    // Last clock of current slot
	logic                load;

	assign load    = tx_start && !tx_busy;
	assign bit_end = tx_busy && (baud_cnt == BIT_LAST);

	////////////////////
	// Line driver
	////////////////////
	always_ff @(posedge clk or posedge rst_s) begin
		if (rst_s) begin
			tx       <= 1'b1;
			tx_busy  <= 1'b0;
			baud_cnt <= '0;
			bit_idx  <= '0;
		end else if (load) begin
			tx       <= 1'b0;    // Start bit next cycle
			tx_busy  <= 1'b1;
			baud_cnt <= '0;
			bit_idx  <= '0;
		end else if (bit_end) begin
			baud_cnt <= '0;
			bit_idx  <= bit_idx + 1'b1;
			if (bit_idx == 4'd9) begin
				tx_busy <= 1'b0;    // Stop bit done
			end else if (bit_idx == 4'd8) begin
				tx <= 1'b1;         // Stop bit
			end else begin
				tx <= shreg[0];
			end
		end else if (tx_busy) begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// Shift register loaded on start
	always_ff @(posedge clk) begin
		if (load)
			shreg <= tx_byte;
		else if (bit_end && bit_idx <= 4'd7)
			shreg <= {1'b0, shreg[7:1]};
	end

endmodule

//--- flist.f
+incdir+design
design/uart_pkg.sv
design/loader_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/packet_parser.sv
design/serial_loader.sv
bench/serial_loader_assert.sv
bench/serial_loader_checker.sv
bench/serial_loader_tb.sv
